/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_tlb_writer
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
src/tlb_writer_pkg.sv
src/sync_fifo.sv
src/tlb_read_probe.sv
src/tlb_write_issue.sv
src/tlb_update_ctrl.sv
src/tlb_writer.sv
sim/axi_lite_slave_model.sv
sim/tb_tlb_writer.sv

/* sim/axi_lite_slave_model.sv */
`timescale 1ns/1ps

module axi_lite_slave_model (
    input  logic                        clk,
    input  logic                        aresetn,
    input  tlb_writer_pkg::axi_wr_req_t wr_req,
    output tlb_writer_pkg::axi_wr_rsp_t wr_rsp,
    input  tlb_writer_pkg::axi_rd_req_t rd_req,
    output tlb_writer_pkg::axi_rd_rsp_t rd_rsp
);

    // Backing store for the TLB region and the replay word
    logic [63:0] mem [logic [63:0]];

    // Chance in percent that a ready or response is offered in a cycle
    int unsigned ready_pct;

    logic aw_got;
    logic w_got;
    logic ar_got;
    logic [63:0] aw_addr;
    logic [63:0] w_data;
    logic [63:0] ar_addr;

    function automatic logic chance();
        return ($urandom % 100) < ready_pct;
    endfunction

    initial begin
        ready_pct = 70;
        wr_rsp = '0;
        rd_rsp = '0;
        aw_got = 1'b0;
        w_got = 1'b0;
        ar_got = 1'b0;
    end

    // Handshakes are taken at the rising edge
    always @(posedge clk) begin
        if (!aresetn) begin
            aw_got = 1'b0;
            w_got = 1'b0;
            ar_got = 1'b0;
        end else begin
            if (wr_req.awvalid && wr_rsp.awready) begin
                aw_addr = wr_req.awaddr;
                aw_got = 1'b1;
            end
            if (wr_req.wvalid && wr_rsp.wready) begin
                w_data = wr_req.wdata;
                w_got = 1'b1;
            end
            if (wr_rsp.bvalid && wr_req.bready) begin
                mem[aw_addr] = w_data;
                aw_got = 1'b0;
                w_got = 1'b0;
            end
            if (rd_req.arvalid && rd_rsp.arready) begin
                ar_addr = rd_req.araddr;
                ar_got = 1'b1;
            end
            if (rd_rsp.rvalid && rd_req.rready) begin
                ar_got = 1'b0;
            end
        end
    end

    // Outputs change on the falling edge, responses hold until taken
    always @(negedge clk) begin
        if (!aresetn) begin
            wr_rsp = '0;
            rd_rsp = '0;
        end else begin
            wr_rsp.awready = !aw_got && chance();
            wr_rsp.wready = !w_got && chance();
            wr_rsp.bvalid = aw_got && w_got && (wr_rsp.bvalid || chance());
            rd_rsp.arready = !ar_got && chance();
            if (ar_got && !rd_rsp.rvalid && chance()) begin
                rd_rsp.rvalid = 1'b1;
                rd_rsp.rdata = mem.exists(ar_addr) ? mem[ar_addr] : 64'd0;
            end else if (!ar_got) begin
                rd_rsp.rvalid = 1'b0;
            end
        end
    end

endmodule

/* sim/tb_tlb_writer.sv */
`timescale 1ns/1ps

module tb_tlb_writer;

    localparam int unsigned N_FREE = 10;
    localparam int unsigned N_FULL = 3;
    localparam int unsigned N_OVERLAP = 4;
    localparam int unsigned N_BURST = 80;
    localparam int unsigned N_GROUP = 4;
    localparam int unsigned N_TESTS = N_FREE + N_FULL + N_OVERLAP + N_BURST;
    localparam int unsigned CLK_PERIOD = 8;
    localparam int unsigned SEED = 74;
    localparam int unsigned FAST_PCT = 70;
    localparam int unsigned SLOW_PCT = 25;
    localparam int unsigned TIMEOUT_NS = N_TESTS * 200 * CLK_PERIOD;

    logic clk;
    logic aresetn;
    tlb_writer_pkg::vaddr_t vaddr;
    logic vaddr_valid;
    logic cache_overlap;
    logic [63:0] h2c_tdata;
    logic h2c_tvalid;
    logic h2c_tready;
    tlb_writer_pkg::axi_wr_req_t wr_req;
    tlb_writer_pkg::axi_wr_rsp_t wr_rsp;
    tlb_writer_pkg::axi_rd_req_t rd_req;
    tlb_writer_pkg::axi_rd_rsp_t rd_rsp;

    // Reference state
    tlb_writer_pkg::translation_t exp_q[$];
    bit shadow [logic [63:0]];
    bit expect_replay;
    int unsigned reads_seen;
    int unsigned accepted;
    int unsigned entries_written;

    tlb_writer_pkg::translation_t chk_t;
    int chk_way;
    bit chk_hit;

    tlb_writer UUT (
        .clk           (clk),
        .aresetn       (aresetn),
        .vaddr         (vaddr),
        .vaddr_valid   (vaddr_valid),
        .cache_overlap (cache_overlap),
        .h2c_tdata     (h2c_tdata),
        .h2c_tvalid    (h2c_tvalid),
        .h2c_tready    (h2c_tready),
        .wr_req        (wr_req),
        .wr_rsp        (wr_rsp),
        .rd_req        (rd_req),
        .rd_rsp        (rd_rsp)
    );

    axi_lite_slave_model mem_slave (
        .clk     (clk),
        .aresetn (aresetn),
        .wr_req  (wr_req),
        .wr_rsp  (wr_rsp),
        .rd_req  (rd_req),
        .rd_rsp  (rd_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic value_error(input string sig, input logic [63:0] expv,
                               input logic [63:0] actv);
        $display("FAILED at %0t ns: %s expected %h, got %h", $time, sig, expv, actv);
        stop_run();
    endtask

    task automatic plain_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    function automatic logic [63:0] way_addr_of(input int way, input logic [63:0] va);
        return tlb_writer_pkg::TLB_BASE_ADDR + 64'(way) * 64'd8192 + 64'(va[21:12]) * 64'd8;
    endfunction

    function automatic logic [63:0] expected_entry(input logic [63:0] va,
                                                   input logic [63:0] pa);
        logic [63:0] tag;
        logic [63:0] ppn;
        tag = va >> 22;
        ppn = pa >> 12;
        return {1'b1, tag[34:0], ppn[27:0]};
    endfunction

    // Completion word with the page address byte-reversed and junk elsewhere
    function automatic logic [63:0] cpl_word(input logic [63:0] pa);
        logic [31:0] junk;
        logic [63:0] w;
        junk = $urandom;
        w = '0;
        w[7:0] = pa[63:56];
        w[15:8] = pa[55:48];
        w[23:16] = pa[47:40];
        w[31:24] = pa[39:32];
        w[39:32] = pa[31:24];
        w[47:40] = pa[23:16];
        w[51:48] = junk[3:0];
        w[55:52] = pa[15:12];
        w[63:56] = junk[11:4];
        return w;
    endfunction

    task automatic preload_ways(input logic [63:0] va, input int count);
        logic [63:0] a;
        for (int i = 0; i < count; i++) begin
            a = way_addr_of(i, va);
            mem_slave.mem[a] = {1'b1, 63'({$urandom, $urandom})};
            shadow[a] = 1'b1;
        end
    endtask

    task automatic push_vaddr(input logic [63:0] va, output logic [63:0] pa);
        tlb_writer_pkg::translation_t t;
        pa = {$urandom, $urandom};
        pa[11:0] = '0;
        t.vaddr = va;
        t.paddr = pa;
        exp_q.push_back(t);
        @(negedge clk);
        vaddr = va;
        vaddr_valid = 1'b1;
        @(negedge clk);
        vaddr_valid = 1'b0;
    endtask

    task automatic send_completion(input logic [63:0] pa);
        h2c_tdata = cpl_word(pa);
        h2c_tvalid = 1'b1;
        while (!h2c_tready) @(negedge clk);
        @(negedge clk);
        h2c_tvalid = 1'b0;
    endtask

    task automatic send_translation(input logic [63:0] va);
        logic [63:0] pa;
        push_vaddr(va, pa);
        send_completion(pa);
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || expect_replay) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    // Write checker against the reference queue and the shadow TLB
    always @(posedge clk) begin
        if (aresetn) begin
            if (rd_req.arvalid && rd_rsp.arready) begin
                if (exp_q.size() == 0) begin
                    plain_error("way read with no translation pending");
                end else begin
                    assert (rd_req.araddr == way_addr_of(int'(reads_seen), exp_q[0].vaddr))
                        else value_error("araddr",
                                         way_addr_of(int'(reads_seen), exp_q[0].vaddr),
                                         rd_req.araddr);
                end
                reads_seen++;
            end
            if (h2c_tvalid && h2c_tready) accepted++;
            if (wr_rsp.bvalid && wr_req.bready) begin
                if (expect_replay) begin
                    assert (wr_req.awaddr == tlb_writer_pkg::REPLAY_ADDR)
                        else value_error("awaddr", tlb_writer_pkg::REPLAY_ADDR, wr_req.awaddr);
                    assert (wr_req.wdata == tlb_writer_pkg::REPLAY_DATA)
                        else value_error("wdata", tlb_writer_pkg::REPLAY_DATA, wr_req.wdata);
                    expect_replay = 1'b0;
                end else if (exp_q.size() == 0) begin
                    plain_error("entry write with no translation pending");
                end else begin
                    chk_t = exp_q.pop_front();
                    chk_way = 4;
                    for (int i = 3; i >= 0; i--) begin
                        if (!shadow.exists(way_addr_of(i, chk_t.vaddr))) chk_way = i;
                    end
                    assert (wr_req.wdata == expected_entry(chk_t.vaddr, chk_t.paddr))
                        else value_error("wdata", expected_entry(chk_t.vaddr, chk_t.paddr),
                                         wr_req.wdata);
                    if (chk_way < 4) begin
                        assert (wr_req.awaddr == way_addr_of(chk_way, chk_t.vaddr))
                            else value_error("awaddr", way_addr_of(chk_way, chk_t.vaddr),
                                             wr_req.awaddr);
                        assert (reads_seen == chk_way + 1)
                            else value_error("read count", 64'(chk_way + 1), 64'(reads_seen));
                    end else begin
                        chk_hit = 1'b0;
                        for (int i = 0; i < 4; i++) begin
                            if (wr_req.awaddr == way_addr_of(i, chk_t.vaddr)) chk_hit = 1'b1;
                        end
                        assert (chk_hit) else plain_error("victim write outside the full set");
                        assert (reads_seen == 4)
                            else value_error("read count", 64'd4, 64'(reads_seen));
                    end
                    shadow[wr_req.awaddr] = 1'b1;
                    reads_seen = 0;
                    entries_written++;
                    expect_replay = !cache_overlap;
                end
            end
        end
    end

    // Handshake rules
    assert property (@(posedge clk) disable iff (!aresetn)
        wr_req.awvalid && !wr_rsp.awready |=> wr_req.awvalid)
        else plain_error("awvalid dropped before awready");
    assert property (@(posedge clk) disable iff (!aresetn)
        wr_req.wvalid && !wr_rsp.wready |=> wr_req.wvalid)
        else plain_error("wvalid dropped before wready");
    assert property (@(posedge clk) disable iff (!aresetn)
        rd_req.arvalid && !rd_rsp.arready |=> rd_req.arvalid)
        else plain_error("arvalid dropped before arready");
    assert property (@(posedge clk) disable iff (!aresetn)
        wr_req.bready && !wr_rsp.bvalid |=> wr_req.bready)
        else plain_error("bready dropped before bvalid");
    assert property (@(posedge clk) disable iff (!aresetn)
        rd_req.rready && !rd_rsp.rvalid |=> rd_req.rready)
        else plain_error("rready dropped before rvalid");
    assert property (@(posedge clk) !aresetn |=> (!wr_req.awvalid && !wr_req.wvalid &&
        !wr_req.bready && !rd_req.arvalid && !rd_req.rready && h2c_tready))
        else plain_error("valid or ready in wrong state during reset");
    // Head entry may still be in its final write when the count has dropped
    assert property (@(posedge clk) disable iff (!aresetn)
        !h2c_tready |-> (accepted - entries_written >= tlb_writer_pkg::FIFO_DEPTH - 1))
        else plain_error("h2c_tready low while translation FIFO not full");

    initial begin
        #(TIMEOUT_NS);
        plain_error("timeout waiting for translations to complete");
    end

    initial begin
        logic [63:0] va;
        logic [63:0] burst_pa [N_GROUP];
        void'($urandom(SEED));
        aresetn = 1'b0;
        vaddr = '0;
        vaddr_valid = 1'b0;
        cache_overlap = 1'b0;
        h2c_tdata = '0;
        h2c_tvalid = 1'b0;
        expect_replay = 1'b0;
        reads_seen = 0;
        accepted = 0;
        entries_written = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;
        mem_slave.ready_pct = FAST_PCT;

        for (int n = 0; n < N_FREE; n++) begin
            va = {$urandom, $urandom};
            preload_ways(va, int'($urandom % 4));
            send_translation(va);
            drain();
        end

        for (int n = 0; n < N_FULL; n++) begin
            va = {$urandom, $urandom};
            preload_ways(va, 4);
            send_translation(va);
            drain();
        end

        cache_overlap = 1'b1;
        repeat (2) @(negedge clk);
        for (int n = 0; n < N_OVERLAP; n++) begin
            va = {$urandom, $urandom};
            send_translation(va);
            drain();
        end
        cache_overlap = 1'b0;
        repeat (2) @(negedge clk);

        // Slow slave lets the translation FIFO fill up
        // Each group of vaddrs goes out ahead of its completions
        mem_slave.ready_pct = SLOW_PCT;
        for (int n = 0; n < N_BURST; n += N_GROUP) begin
            for (int i = 0; i < N_GROUP; i++) begin
                va = {$urandom, $urandom};
                push_vaddr(va, burst_pa[i]);
            end
            for (int i = 0; i < N_GROUP; i++) begin
                send_completion(burst_pa[i]);
            end
        end
        drain();

        $display("All tests passed");
        $finish;
    end

endmodule

/* src/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     aresetn,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     empty,
    output logic     full
);

    payload_t mem [tlb_writer_pkg::FIFO_DEPTH];

    logic [tlb_writer_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [tlb_writer_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [tlb_writer_pkg::FIFO_CNT_W-1:0] count;
    logic wr_en;
    logic rd_en;

    // Pushes into a full buffer are dropped
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign empty = (count == '0);
    assign full = (count == tlb_writer_pkg::FIFO_CNT_W'(tlb_writer_pkg::FIFO_DEPTH));

    // Head shows without a read cycle
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* src/tlb_read_probe.sv */
`timescale 1ns/1ps

module tlb_read_probe (
    input  logic                                clk,
    input  logic                                aresetn,
    input  logic                                start,
    input  logic [tlb_writer_pkg::ADDR_W-1:0]   addr,
    output tlb_writer_pkg::axi_rd_req_t         rd_req,
    input  tlb_writer_pkg::axi_rd_rsp_t         rd_rsp,
    output logic                                done,
    output logic                                entry_valid
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } state_t;

    state_t state;
    logic [tlb_writer_pkg::ADDR_W-1:0] araddr_q;
    logic arvalid;
    logic rready;

    assign rd_req = '{araddr: araddr_q, arvalid: arvalid, rready: rready};

    // Entry data only needs its valid bit
    always_ff @(posedge clk) begin
        if (start && state == S_IDLE) begin
            araddr_q <= addr;
        end
        if (state == S_DATA && rd_rsp.rvalid) begin
            entry_valid <= rd_rsp.rdata[63];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= S_IDLE;
            arvalid <= 1'b0;
            rready <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        arvalid <= 1'b1;
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (rd_rsp.arready) begin
                        arvalid <= 1'b0;
                        rready <= 1'b1;
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (rd_rsp.rvalid) begin
                        rready <= 1'b0;
                        done <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* src/tlb_update_ctrl.sv */
`timescale 1ns/1ps

module tlb_update_ctrl (
    input  logic                                clk,
    input  logic                                aresetn,
    input  logic                                cache_overlap,
    input  tlb_writer_pkg::translation_t        head,
    input  logic                                head_valid,
    output logic                                pop,
    output logic                                probe_start,
    output logic [tlb_writer_pkg::ADDR_W-1:0]   probe_addr,
    input  logic                                probe_done,
    input  logic                                probe_entry_valid,
    output logic                                write_start,
    output logic [tlb_writer_pkg::ADDR_W-1:0]   write_addr,
    output logic [tlb_writer_pkg::DATA_W-1:0]   write_data,
    input  logic                                write_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_PROBE,
        S_WR_ENTRY,
        S_WR_REPLAY
    } state_t;

    state_t state;
    logic cache_overlap_q;
    logic [tlb_writer_pkg::WAY_W-1:0] cycle_cnt;
    logic [tlb_writer_pkg::WAY_W-1:0] way;
    logic [tlb_writer_pkg::ADDR_W-1:0] way_addr;
    logic last_way;

    assign way_addr = tlb_writer_pkg::tlb_way_addr(way, head.vaddr);
    assign last_way = (way == tlb_writer_pkg::WAY_W'(tlb_writer_pkg::TLB_WAYS - 1));

    assign probe_addr = way_addr;

    // Replay word replaces the entry once the entry write is done
    always_comb begin
        if (state == S_WR_REPLAY) begin
            write_addr = tlb_writer_pkg::REPLAY_ADDR;
            write_data = tlb_writer_pkg::REPLAY_DATA;
        end else begin
            write_addr = way_addr;
            write_data = tlb_writer_pkg::tlb_entry(head.vaddr, head.paddr);
        end
    end

    // Head is released as soon as the entry is in the TLB
    assign pop = (state == S_WR_ENTRY) && write_done;

    // Overlap flag takes effect one cycle late
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            cache_overlap_q <= 1'b0;
        end else begin
            cache_overlap_q <= cache_overlap;
        end
    end

    // Free-running counter doubles as victim picker
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= S_IDLE;
            way <= '0;
            probe_start <= 1'b0;
            write_start <= 1'b0;
        end else begin
            probe_start <= 1'b0;
            write_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (head_valid) begin
                        way <= '0;
                        probe_start <= 1'b1;
                        state <= S_PROBE;
                    end
                end
                S_PROBE: begin
                    if (probe_done) begin
                        if (!probe_entry_valid) begin
                            write_start <= 1'b1;
                            state <= S_WR_ENTRY;
                        end else if (last_way) begin
                            // Set is full so evict a pseudo-random way
                            way <= cycle_cnt;
                            write_start <= 1'b1;
                            state <= S_WR_ENTRY;
                        end else begin
                            way <= way + 1'b1;
                            probe_start <= 1'b1;
                        end
                    end
                end
                S_WR_ENTRY: begin
                    if (write_done) begin
                        if (!cache_overlap_q) begin
                            write_start <= 1'b1;
                            state <= S_WR_REPLAY;
                        end else begin
                            state <= S_IDLE;
                        end
                    end
                end
                S_WR_REPLAY: begin
                    if (write_done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* src/tlb_write_issue.sv */
`timescale 1ns/1ps

module tlb_write_issue (
    input  logic                                clk,
    input  logic                                aresetn,
    input  logic                                start,
    input  logic [tlb_writer_pkg::ADDR_W-1:0]   addr,
    input  logic [tlb_writer_pkg::DATA_W-1:0]   data,
    output tlb_writer_pkg::axi_wr_req_t         wr_req,
    input  tlb_writer_pkg::axi_wr_rsp_t         wr_rsp,
    output logic                                done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_RESP
    } state_t;

    state_t state;
    logic [tlb_writer_pkg::ADDR_W-1:0] awaddr_q;
    logic [tlb_writer_pkg::DATA_W-1:0] wdata_q;
    logic awvalid;
    logic wvalid;
    logic bready;
    logic aw_seen;
    logic w_seen;
    logic aw_hs;
    logic w_hs;

    assign wr_req = '{awaddr: awaddr_q, awvalid: awvalid, wdata: wdata_q,
                      wvalid: wvalid, bready: bready};

    assign aw_hs = awvalid && wr_rsp.awready;
    assign w_hs = wvalid && wr_rsp.wready;

    always_ff @(posedge clk) begin
        if (start && state == S_IDLE) begin
            awaddr_q <= addr;
            wdata_q <= data;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= S_IDLE;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= 1'b0;
            aw_seen <= 1'b0;
            w_seen <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        awvalid <= 1'b1;
                        wvalid <= 1'b1;
                        aw_seen <= 1'b0;
                        w_seen <= 1'b0;
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    // Address and data channels may finish in any order
                    if (aw_hs) begin
                        awvalid <= 1'b0;
                        aw_seen <= 1'b1;
                    end
                    if (w_hs) begin
                        wvalid <= 1'b0;
                        w_seen <= 1'b1;
                    end
                    if ((aw_seen || aw_hs) && (w_seen || w_hs)) begin
                        bready <= 1'b1;
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (wr_rsp.bvalid) begin
                        bready <= 1'b0;
                        done <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* src/tlb_writer.sv */
`timescale 1ns/1ps

module tlb_writer (
    input  logic                                clk,
    input  logic                                aresetn,
    input  tlb_writer_pkg::vaddr_t              vaddr,
    input  logic                                vaddr_valid,
    input  logic                                cache_overlap,
    input  logic [tlb_writer_pkg::DATA_W-1:0]   h2c_tdata,
    input  logic                                h2c_tvalid,
    output logic                                h2c_tready,
    output tlb_writer_pkg::axi_wr_req_t         wr_req,
    input  tlb_writer_pkg::axi_wr_rsp_t         wr_rsp,
    output tlb_writer_pkg::axi_rd_req_t         rd_req,
    input  tlb_writer_pkg::axi_rd_rsp_t         rd_rsp
);

    tlb_writer_pkg::vaddr_t inflight_vaddr;
    tlb_writer_pkg::translation_t trans_in;
    tlb_writer_pkg::translation_t trans_head;
    logic cpl_accept;
    logic trans_empty;
    logic trans_full;
    logic trans_pop;

    logic probe_start;
    logic [tlb_writer_pkg::ADDR_W-1:0] probe_addr;
    logic probe_done;
    logic probe_entry_valid;
    logic write_start;
    logic [tlb_writer_pkg::ADDR_W-1:0] write_addr;
    logic [tlb_writer_pkg::DATA_W-1:0] write_data;
    logic write_done;

    assign h2c_tready = !trans_full;
    assign cpl_accept = h2c_tvalid && h2c_tready;

    // Oldest outstanding vaddr belongs to this completion
    assign trans_in.vaddr = inflight_vaddr;
    assign trans_in.paddr = tlb_writer_pkg::paddr_from_completion(h2c_tdata);

    sync_fifo #(.payload_t(tlb_writer_pkg::vaddr_t)) in_flight_fifo (
        .clk     (clk),
        .aresetn (aresetn),
        .push    (vaddr_valid),
        .din     (vaddr),
        .pop     (cpl_accept),
        .dout    (inflight_vaddr),
        .empty   (),
        .full    ()
    );

    sync_fifo #(.payload_t(tlb_writer_pkg::translation_t)) trans_fifo (
        .clk     (clk),
        .aresetn (aresetn),
        .push    (cpl_accept),
        .din     (trans_in),
        .pop     (trans_pop),
        .dout    (trans_head),
        .empty   (trans_empty),
        .full    (trans_full)
    );

    tlb_read_probe u_read_probe (
        .clk         (clk),
        .aresetn     (aresetn),
        .start       (probe_start),
        .addr        (probe_addr),
        .rd_req      (rd_req),
        .rd_rsp      (rd_rsp),
        .done        (probe_done),
        .entry_valid (probe_entry_valid)
    );

    tlb_write_issue u_write_issue (
        .clk     (clk),
        .aresetn (aresetn),
        .start   (write_start),
        .addr    (write_addr),
        .data    (write_data),
        .wr_req  (wr_req),
        .wr_rsp  (wr_rsp),
        .done    (write_done)
    );

    tlb_update_ctrl u_update_ctrl (
        .clk               (clk),
        .aresetn           (aresetn),
        .cache_overlap     (cache_overlap),
        .head              (trans_head),
        .head_valid        (!trans_empty),
        .pop               (trans_pop),
        .probe_start       (probe_start),
        .probe_addr        (probe_addr),
        .probe_done        (probe_done),
        .probe_entry_valid (probe_entry_valid),
        .write_start       (write_start),
        .write_addr        (write_addr),
        .write_data        (write_data),
        .write_done        (write_done)
    );

endmodule

/* src/tlb_writer_pkg.sv */
package tlb_writer_pkg;

    // Bus widths
    localparam int unsigned ADDR_W = 64;
    localparam int unsigned DATA_W = 64;

    // TLB geometry
    localparam int unsigned TLB_WAYS = 4;
    localparam int unsigned WAY_W = 2;
    localparam int unsigned PAGE_SHIFT = 12;
    localparam int unsigned SET_BITS = 10;
    localparam int unsigned TAG_W = 35;
    localparam int unsigned PPN_W = 28;
    localparam int unsigned WAY_STRIDE_SHIFT = 13;
    localparam int unsigned ENTRY_SHIFT = 3;

    // Address map
    localparam logic [ADDR_W-1:0] TLB_BASE_ADDR = 64'h0000_0000_0011_0000;
    localparam logic [ADDR_W-1:0] REPLAY_ADDR = 64'h0000_0000_0100_0000;
    localparam logic [DATA_W-1:0] REPLAY_DATA = 64'h0000_0000_0000_0100;

    // FIFO sizing
    localparam int unsigned FIFO_DEPTH = 64;
    localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned FIFO_CNT_W = FIFO_PTR_W + 1;

    typedef logic [ADDR_W-1:0] vaddr_t;

    typedef struct packed {
        vaddr_t            vaddr;
        logic [ADDR_W-1:0] paddr;
    } translation_t;

    typedef struct packed {
        logic [ADDR_W-1:0] awaddr;
        logic              awvalid;
        logic [DATA_W-1:0] wdata;
        logic              wvalid;
        logic              bready;
    } axi_wr_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } axi_wr_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] araddr;
        logic              arvalid;
        logic              rready;
    } axi_rd_req_t;

    typedef struct packed {
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
    } axi_rd_rsp_t;

    // Completion carries the physical address byte-reversed
    function automatic logic [ADDR_W-1:0] paddr_from_completion(input logic [DATA_W-1:0] cpl);
        return {cpl[7:0], cpl[15:8], cpl[23:16], cpl[31:24], cpl[39:32], cpl[47:40],
                cpl[55:52], 12'd0};
    endfunction

    function automatic logic [DATA_W-1:0] tlb_entry(input vaddr_t vaddr,
                                                    input logic [ADDR_W-1:0] paddr);
        logic [ADDR_W-1:0] tag;
        logic [ADDR_W-1:0] ppn;
        tag = vaddr >> (PAGE_SHIFT + SET_BITS);
        ppn = paddr >> PAGE_SHIFT;
        // Valid bit on top, then tag and page number
        return {1'b1, tag[TAG_W-1:0], ppn[PPN_W-1:0]};
    endfunction

    function automatic logic [ADDR_W-1:0] tlb_way_addr(input logic [WAY_W-1:0] way,
                                                       input vaddr_t vaddr);
        logic [ADDR_W-1:0] set_idx;
        set_idx = ADDR_W'(vaddr[PAGE_SHIFT +: SET_BITS]);
        return TLB_BASE_ADDR + (ADDR_W'(way) << WAY_STRIDE_SHIFT) + (set_idx << ENTRY_SHIFT);
    endfunction

endpackage
